/* common/bank_defines.svh */
`ifndef BANK_DEFINES_SVH
`define BANK_DEFINES_SVH

// set/way/offset index, bit 0 picks the half
`define BANK_IDX_W   7
// sram address, index bits 6:1
`define BANK_ADDR_W  6

// one half line
`define BANK_HALF_W  128

// side-band tags
`define BANK_WBID_W  8
`define BANK_ROB_W   3
`define BANK_CH_W    2

`endif

/* common/bank_op_pkg.sv */
`default_nettype none

package bank_op_pkg;

  // issue opcodes
  typedef enum logic [2:0] {
    WRITE         = 3'd0,
    READ          = 3'd1,
    READ_LINEFILL = 3'd2,
    WRITE_BACK    = 3'd3
  } opcode_e;

  // per-half line state from the issue unit
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    SYNC  = 2'd1,
    DIRTY = 2'd2
  } line_state_e;

  // sequencer phase
  typedef enum logic [1:0] {
    ACCESS = 2'd0,
    RESULT = 2'd1,
    HELD   = 2'd2
  } phase_e;

endpackage

`default_nettype wire

/* common/bank_data_pkg.sv */
`default_nettype none

`include "bank_defines.svh"

package bank_data_pkg;

  // one offset of a cache line
  typedef logic [`BANK_HALF_W-1:0] half_t;

  // offset1 in the upper half
  typedef logic [2*`BANK_HALF_W-1:0] line_t;

  // byte strobes, upper 16 belong to offset1
  typedef logic [2*`BANK_HALF_W/8-1:0] strb_t;

endpackage

`default_nettype wire

/* src/ram_sp.sv */
`default_nettype none

module ram_sp #(
  parameter int AW = 6,
  parameter int DW = 128
) (
  input  logic          clk_i,
  input  logic          en_i,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  logic [DW-1:0] wdata_i,
  output logic [DW-1:0] rdata_o
);

  logic [DW-1:0] mem [0:(1<<AW)-1];

  // single port, read data one cycle after enable
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        // write leaves rdata_o alone
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* bank_ctrl/bank_seq_fsm.sv */
`default_nettype none

module bank_seq_fsm (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  input  bank_op_pkg::opcode_e     req_opcode_i,
  input  logic                     req_offset_i,
  input  bank_op_pkg::line_state_e req_state0_i,
  input  bank_op_pkg::line_state_e req_state1_i,
  input  logic                     wbuf_rtn_valid_i,
  input  logic                     biu_ready_i,
  output bank_op_pkg::phase_e      phase_o,
  output logic                     ram0_en_o,
  output logic                     ram0_we_o,
  output logic                     ram1_en_o,
  output logic                     ram1_we_o,
  output logic                     buf_load_o,
  output logic                     wbuf_req_valid_o,
  output logic                     xbar_valid_o,
  output logic                     biu_valid_o,
  output logic                     req_ready_o
);

  bank_op_pkg::phase_e phase_q;
  bank_op_pkg::phase_e phase_d;

  logic op_write;
  logic op_read;
  logic op_fill;
  logic op_wb;
  logic in_access;
  logic in_result;
  logic in_held;
  logic wr_return;
  logic touch0;
  logic touch1;
  logic array_en;
  logic array_we;
  logic done;

  // ------------------------------------------------------------------
  // request decode
  // ------------------------------------------------------------------
  assign op_write = req_valid_i & (req_opcode_i == bank_op_pkg::WRITE);
  assign op_read  = req_valid_i & (req_opcode_i == bank_op_pkg::READ);
  assign op_fill  = req_valid_i & (req_opcode_i == bank_op_pkg::READ_LINEFILL);
  assign op_wb    = req_valid_i & (req_opcode_i == bank_op_pkg::WRITE_BACK);

  assign in_access = (phase_q == bank_op_pkg::ACCESS);
  assign in_result = (phase_q == bank_op_pkg::RESULT);
  assign in_held   = (phase_q == bank_op_pkg::HELD);

  // write data arrives from the write buffer
  assign wr_return = in_result & op_write & wbuf_rtn_valid_i;

  // selected half, plus empty halves on linefill and dirty halves on write back
  assign touch0 = ~req_offset_i
                | (op_fill & (req_state0_i == bank_op_pkg::EMPTY))
                | (op_wb   & (req_state0_i == bank_op_pkg::DIRTY));
  assign touch1 = req_offset_i
                | (op_fill & (req_state1_i == bank_op_pkg::EMPTY))
                | (op_wb   & (req_state1_i == bank_op_pkg::DIRTY));

  // ------------------------------------------------------------------
  // array strobes
  // ------------------------------------------------------------------
  assign array_en = (in_access & (op_read | op_fill | op_wb)) | wr_return;
  assign array_we = (in_access & op_fill) | wr_return;

  assign ram0_en_o = touch0 & array_en;
  assign ram0_we_o = touch0 & array_we;
  assign ram1_en_o = touch1 & array_en;
  assign ram1_we_o = touch1 & array_we;

  // ------------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------------
  assign wbuf_req_valid_o = in_access & op_write;

  // linefill data leaves at once, sram data one cycle later
  assign xbar_valid_o = (in_access & op_fill) | (in_result & op_read);

  // write back live in RESULT, from the buffer in HELD
  assign biu_valid_o = op_wb & (in_result | in_held);
  assign buf_load_o  = op_wb & in_result;

  assign done = (in_result & (op_read | op_fill))
              | wr_return
              | (biu_valid_o & biu_ready_i);

  assign req_ready_o = done;

  // ------------------------------------------------------------------
  // phase register
  // ------------------------------------------------------------------
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      bank_op_pkg::ACCESS: begin
        if (op_read | op_fill | op_wb | op_write) begin
          phase_d = bank_op_pkg::RESULT;
        end
      end
      bank_op_pkg::RESULT: begin
        if (done) begin
          phase_d = bank_op_pkg::ACCESS;
        end else if (op_wb) begin
          // bus interface stalled, keep the line in the buffer
          phase_d = bank_op_pkg::HELD;
        end
      end
      bank_op_pkg::HELD: begin
        if (done) begin
          phase_d = bank_op_pkg::ACCESS;
        end
      end
      default: begin
        phase_d = bank_op_pkg::ACCESS;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      phase_q <= bank_op_pkg::ACCESS;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign phase_o = phase_q;

endmodule

`default_nettype wire

/* bank_ctrl/bank_datapath.sv */
`default_nettype none

`include "bank_defines.svh"

module bank_datapath (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  bank_op_pkg::phase_e      phase_i,
  input  bank_op_pkg::opcode_e     opcode_i,
  input  logic                     offset_i,
  input  bank_op_pkg::line_state_e state0_i,
  input  bank_op_pkg::line_state_e state1_i,
  input  logic                     buf_load_i,
  input  bank_data_pkg::half_t     fill0_i,
  input  bank_data_pkg::half_t     fill1_i,
  input  bank_data_pkg::half_t     wbuf_rtn_data_i,
  input  bank_data_pkg::half_t     ram0_rdata_i,
  input  bank_data_pkg::half_t     ram1_rdata_i,
  output bank_data_pkg::half_t     ram0_wdata_o,
  output bank_data_pkg::half_t     ram1_wdata_o,
  output bank_data_pkg::half_t     xbar_data_o,
  output bank_data_pkg::line_t     biu_data_o,
  output bank_data_pkg::strb_t     biu_strb_o
);

  localparam int HALF_BYTES = `BANK_HALF_W / 8;

  logic                 is_fill;
  logic                 is_wb;
  logic                 need0;
  logic                 need1;
  bank_data_pkg::half_t fill_sel;
  bank_data_pkg::half_t ram_sel;
  bank_data_pkg::line_t live_line;
  bank_data_pkg::line_t buf_q;

  assign is_fill = (opcode_i == bank_op_pkg::READ_LINEFILL);
  assign is_wb   = (opcode_i == bank_op_pkg::WRITE_BACK);

  // ------------------------------------------------------------------
  // sram write data
  // ------------------------------------------------------------------
  // fill data on linefill, write buffer return otherwise
  assign ram0_wdata_o = is_fill ? fill0_i : wbuf_rtn_data_i;
  assign ram1_wdata_o = is_fill ? fill1_i : wbuf_rtn_data_i;

  // ------------------------------------------------------------------
  // crossbar data
  // ------------------------------------------------------------------
  assign fill_sel = offset_i ? fill1_i : fill0_i;
  assign ram_sel  = offset_i ? ram1_rdata_i : ram0_rdata_i;

  assign xbar_data_o = is_fill ? fill_sel : ram_sel;

  // ------------------------------------------------------------------
  // write back line
  // ------------------------------------------------------------------
  // halves that go to the bus interface
  assign need0 = ~offset_i | (is_wb & (state0_i == bank_op_pkg::DIRTY));
  assign need1 = offset_i | (is_wb & (state1_i == bank_op_pkg::DIRTY));

  // unneeded halves read as zero
  assign live_line = {need1 ? ram1_rdata_i : '0,
                      need0 ? ram0_rdata_i : '0};

  // read buffer, keeps the line across a bus stall
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      buf_q <= '0;
    end else if (buf_load_i) begin
      buf_q <= live_line;
    end
  end

  assign biu_data_o = (phase_i == bank_op_pkg::HELD) ? buf_q : live_line;
  assign biu_strb_o = {{HALF_BYTES{need1}}, {HALF_BYTES{need0}}};

endmodule

`default_nettype wire

/* src/bank_sram_controller.sv */
`default_nettype none

`include "bank_defines.svh"

module bank_sram_controller (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // issue side
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  bank_op_pkg::opcode_e     req_opcode_i,
  input  logic [`BANK_IDX_W-1:0]   req_idx_i,
  input  bank_op_pkg::line_state_e req_state0_i,
  input  bank_op_pkg::line_state_e req_state1_i,
  input  logic [`BANK_WBID_W-1:0]  req_wbuf_id_i,
  input  logic [`BANK_CH_W-1:0]    req_channel_i,
  input  logic [`BANK_ROB_W-1:0]   req_rob_i,
  input  bank_data_pkg::half_t     req_fill0_i,
  input  bank_data_pkg::half_t     req_fill1_i,
  // crossbar
  output logic                     xbar_valid_o,
  output bank_data_pkg::half_t     xbar_data_o,
  output logic [`BANK_CH_W-1:0]    xbar_channel_o,
  output logic [`BANK_ROB_W-1:0]   xbar_rob_o,
  // write buffer
  output logic                     wbuf_req_valid_o,
  output logic [`BANK_WBID_W-1:0]  wbuf_req_id_o,
  input  logic                     wbuf_rtn_valid_i,
  input  bank_data_pkg::half_t     wbuf_rtn_data_i,
  // bus interface
  output logic                     biu_valid_o,
  input  logic                     biu_ready_i,
  output bank_data_pkg::line_t     biu_data_o,
  output bank_data_pkg::strb_t     biu_strb_o,
  output logic [`BANK_ADDR_W-1:0]  biu_addr_o
);

  bank_op_pkg::phase_e      phase;
  logic                     offset;
  logic [`BANK_ADDR_W-1:0]  ram_addr;
  logic                     ram0_en;
  logic                     ram0_we;
  logic                     ram1_en;
  logic                     ram1_we;
  logic                     buf_load;
  bank_data_pkg::half_t     ram0_wdata;
  bank_data_pkg::half_t     ram1_wdata;
  bank_data_pkg::half_t     ram0_rdata;
  bank_data_pkg::half_t     ram1_rdata;

  // bit 0 picks the half, the rest addresses both srams
  assign offset   = req_idx_i[0];
  assign ram_addr = req_idx_i[`BANK_IDX_W-1:1];

  assign biu_addr_o     = ram_addr;
  assign wbuf_req_id_o  = req_wbuf_id_i;
  assign xbar_channel_o = req_channel_i;
  assign xbar_rob_o     = req_rob_i;

  bank_seq_fsm u_seq_fsm (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_opcode_i     (req_opcode_i),
    .req_offset_i     (offset),
    .req_state0_i     (req_state0_i),
    .req_state1_i     (req_state1_i),
    .wbuf_rtn_valid_i (wbuf_rtn_valid_i),
    .biu_ready_i      (biu_ready_i),
    .phase_o          (phase),
    .ram0_en_o        (ram0_en),
    .ram0_we_o        (ram0_we),
    .ram1_en_o        (ram1_en),
    .ram1_we_o        (ram1_we),
    .buf_load_o       (buf_load),
    .wbuf_req_valid_o (wbuf_req_valid_o),
    .xbar_valid_o     (xbar_valid_o),
    .biu_valid_o      (biu_valid_o),
    .req_ready_o      (req_ready_o)
  );

  bank_datapath u_datapath (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .phase_i         (phase),
    .opcode_i        (req_opcode_i),
    .offset_i        (offset),
    .state0_i        (req_state0_i),
    .state1_i        (req_state1_i),
    .buf_load_i      (buf_load),
    .fill0_i         (req_fill0_i),
    .fill1_i         (req_fill1_i),
    .wbuf_rtn_data_i (wbuf_rtn_data_i),
    .ram0_rdata_i    (ram0_rdata),
    .ram1_rdata_i    (ram1_rdata),
    .ram0_wdata_o    (ram0_wdata),
    .ram1_wdata_o    (ram1_wdata),
    .xbar_data_o     (xbar_data_o),
    .biu_data_o      (biu_data_o),
    .biu_strb_o      (biu_strb_o)
  );

  // ------------------------------------------------------------------
  // data arrays, 64 x 128 per offset
  // ------------------------------------------------------------------
  ram_sp #(
    .AW (`BANK_ADDR_W),
    .DW (`BANK_HALF_W)
  ) u_offset0_ram (
    .clk_i   (clk_i),
    .en_i    (ram0_en),
    .we_i    (ram0_we),
    .addr_i  (ram_addr),
    .wdata_i (ram0_wdata),
    .rdata_o (ram0_rdata)
  );

  ram_sp #(
    .AW (`BANK_ADDR_W),
    .DW (`BANK_HALF_W)
  ) u_offset1_ram (
    .clk_i   (clk_i),
    .en_i    (ram1_en),
    .we_i    (ram1_we),
    .addr_i  (ram_addr),
    .wdata_i (ram1_wdata),
    .rdata_o (ram1_rdata)
  );

endmodule

`default_nettype wire

/* tests/bank_sram_assertions.sv */
`default_nettype none

`include "bank_defines.svh"

module bank_sram_assertions (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    req_valid_i,
  input logic                    req_ready_i,
  input logic                    xbar_valid_i,
  input logic                    wbuf_req_valid_i,
  input logic                    biu_valid_i,
  input logic                    biu_ready_i,
  input bank_data_pkg::line_t    biu_data_i,
  input bank_data_pkg::strb_t    biu_strb_i,
  input logic [`BANK_ADDR_W-1:0] biu_addr_i
);

  // one failure counter per property
  int unsigned ready_fails  = 0;
  int unsigned stable_fails = 0;
  int unsigned pulse_fails  = 0;
  int unsigned reset_fails  = 0;

  // completion only for a presented request
  ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i) req_ready_i |-> req_valid_i
  ) else begin
    $error("req_ready_o high without req_valid_i");
    ready_fails++;
  end

  // bus interface payload frozen while stalled
  biu_hold_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (biu_valid_i && !biu_ready_i) |=>
      (biu_valid_i && $stable(biu_data_i) && $stable(biu_strb_i) && $stable(biu_addr_i))
  ) else begin
    $error("bus interface outputs changed during a stall");
    stable_fails++;
  end

  xbar_single_pulse: assert property (
    @(posedge clk_i) disable iff (rst_i) xbar_valid_i |=> !xbar_valid_i
  ) else begin
    $error("xbar_valid_o held longer than one cycle");
    pulse_fails++;
  end

  quiet_in_reset: assert property (
    @(posedge clk_i) rst_i |-> !(req_ready_i || xbar_valid_i || wbuf_req_valid_i || biu_valid_i)
  ) else begin
    $error("control output high during reset");
    reset_fails++;
  end

endmodule

bind bank_sram_controller bank_sram_assertions u_bank_sram_assertions (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .req_valid_i      (req_valid_i),
  .req_ready_i      (req_ready_o),
  .xbar_valid_i     (xbar_valid_o),
  .wbuf_req_valid_i (wbuf_req_valid_o),
  .biu_valid_i      (biu_valid_o),
  .biu_ready_i      (biu_ready_i),
  .biu_data_i       (biu_data_o),
  .biu_strb_i       (biu_strb_o),
  .biu_addr_i       (biu_addr_o)
);

`default_nettype wire

/* tests/bank_sram_tb.sv */
`default_nettype none

`include "bank_defines.svh"

module bank_sram_tb;

  localparam int    MAX_CYCLES = 64;
  localparam string TRACE_FILE = "tests/bank_sram_trace.txt";

  logic                     clk_i;
  logic                     rst_i;
  logic                     req_valid_i;
  logic                     req_ready_o;
  bank_op_pkg::opcode_e     req_opcode_i;
  logic [`BANK_IDX_W-1:0]   req_idx_i;
  bank_op_pkg::line_state_e req_state0_i;
  bank_op_pkg::line_state_e req_state1_i;
  logic [`BANK_WBID_W-1:0]  req_wbuf_id_i;
  logic [`BANK_CH_W-1:0]    req_channel_i;
  logic [`BANK_ROB_W-1:0]   req_rob_i;
  bank_data_pkg::half_t     req_fill0_i;
  bank_data_pkg::half_t     req_fill1_i;
  logic                     xbar_valid_o;
  bank_data_pkg::half_t     xbar_data_o;
  logic [`BANK_CH_W-1:0]    xbar_channel_o;
  logic [`BANK_ROB_W-1:0]   xbar_rob_o;
  logic                     wbuf_req_valid_o;
  logic [`BANK_WBID_W-1:0]  wbuf_req_id_o;
  logic                     wbuf_rtn_valid_i;
  bank_data_pkg::half_t     wbuf_rtn_data_i;
  logic                     biu_valid_o;
  logic                     biu_ready_i;
  bank_data_pkg::line_t     biu_data_o;
  bank_data_pkg::strb_t     biu_strb_o;
  logic [`BANK_ADDR_W-1:0]  biu_addr_o;

  int checks = 0;
  int errors = 0;
  bit timed_out = 1'b0;

  // current trace line
  logic [2:0]              t_op;
  logic [`BANK_IDX_W-1:0]  t_idx;
  logic [1:0]              t_st0;
  logic [1:0]              t_st1;
  logic [`BANK_WBID_W-1:0] t_wbid;
  logic [`BANK_CH_W-1:0]   t_ch;
  logic [`BANK_ROB_W-1:0]  t_rob;
  logic [31:0]             t_fill0;
  logic [31:0]             t_fill1;
  logic [7:0]              t_wdly;
  logic [31:0]             t_wdata;
  logic [7:0]              t_stall;
  logic [31:0]             t_xbar;
  logic [31:0]             t_biu_hi;
  logic [31:0]             t_biu_lo;
  logic [31:0]             t_strb;

  bank_sram_controller i_bank_sram_controller (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_opcode_i     (req_opcode_i),
    .req_idx_i        (req_idx_i),
    .req_state0_i     (req_state0_i),
    .req_state1_i     (req_state1_i),
    .req_wbuf_id_i    (req_wbuf_id_i),
    .req_channel_i    (req_channel_i),
    .req_rob_i        (req_rob_i),
    .req_fill0_i      (req_fill0_i),
    .req_fill1_i      (req_fill1_i),
    .xbar_valid_o     (xbar_valid_o),
    .xbar_data_o      (xbar_data_o),
    .xbar_channel_o   (xbar_channel_o),
    .xbar_rob_o       (xbar_rob_o),
    .wbuf_req_valid_o (wbuf_req_valid_o),
    .wbuf_req_id_o    (wbuf_req_id_o),
    .wbuf_rtn_valid_i (wbuf_rtn_valid_i),
    .wbuf_rtn_data_i  (wbuf_rtn_data_i),
    .biu_valid_o      (biu_valid_o),
    .biu_ready_i      (biu_ready_i),
    .biu_data_o       (biu_data_o),
    .biu_strb_o       (biu_strb_o),
    .biu_addr_o       (biu_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50;
      clk_i = ~clk_i;
    end
  end

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // trace words fill a half four times over
  function automatic bank_data_pkg::half_t expand_word(input logic [31:0] w);
    return {4{w}};
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      check_value("idle strobes", 256'(0),
                  256'({req_ready_o, xbar_valid_o, wbuf_req_valid_o, biu_valid_o}));
      @(negedge clk_i);
    end
  endtask

  // ------------------------------------------------------------------
  // one request against the write buffer and bus interface models
  // ------------------------------------------------------------------
  task automatic run_request(input int num);
    int                   cyc;
    int                   done_cyc;
    int                   wb_wait;
    int                   stall_left;
    int                   xbar_seen;
    int                   xbar_cyc;
    int                   wreq_seen;
    int                   biu_seen;
    bit                   done;
    bank_data_pkg::line_t first_data;
    bank_data_pkg::strb_t first_strb;
    string                tag;
    tag        = $sformatf("req%0d", num);
    cyc        = 0;
    done_cyc   = -1;
    wb_wait    = 0;
    stall_left = int'(t_stall);
    xbar_seen  = 0;
    xbar_cyc   = -1;
    wreq_seen  = 0;
    biu_seen   = 0;
    done       = 1'b0;
    first_data = '0;
    first_strb = '0;

    req_valid_i   = 1'b1;
    req_opcode_i  = bank_op_pkg::opcode_e'(t_op);
    req_idx_i     = t_idx;
    req_state0_i  = bank_op_pkg::line_state_e'(t_st0);
    req_state1_i  = bank_op_pkg::line_state_e'(t_st1);
    req_wbuf_id_i = t_wbid;
    req_channel_i = t_ch;
    req_rob_i     = t_rob;
    req_fill0_i   = expand_word(t_fill0);
    req_fill1_i   = expand_word(t_fill1);
    biu_ready_i   = (stall_left == 0);

    while (!done && cyc < MAX_CYCLES) begin
      @(posedge clk_i);
      if (xbar_valid_o) begin
        xbar_seen++;
        xbar_cyc = cyc;
        check_value({tag, " xbar data"}, 256'(expand_word(t_xbar)), 256'(xbar_data_o));
        check_value({tag, " xbar channel"}, 256'(t_ch), 256'(xbar_channel_o));
        check_value({tag, " xbar rob"}, 256'(t_rob), 256'(xbar_rob_o));
      end
      if (wbuf_req_valid_o) begin
        wreq_seen++;
        wb_wait = int'(t_wdly);
        check_value({tag, " wbuf id"}, 256'(t_wbid), 256'(wbuf_req_id_o));
      end
      if (biu_valid_o) begin
        if (biu_seen == 0) begin
          first_data = biu_data_o;
          first_strb = biu_strb_o;
        end else begin
          check_value({tag, " biu data held"}, 256'(first_data), 256'(biu_data_o));
          check_value({tag, " biu strb held"}, 256'(first_strb), 256'(biu_strb_o));
        end
        biu_seen++;
        if (biu_ready_i) begin
          check_value({tag, " biu data"}, 256'({expand_word(t_biu_hi), expand_word(t_biu_lo)}),
                      256'(biu_data_o));
          check_value({tag, " biu strb"}, 256'(t_strb), 256'(biu_strb_o));
          check_value({tag, " biu addr"}, 256'(t_idx[`BANK_IDX_W-1:1]), 256'(biu_addr_o));
        end else if (stall_left > 0) begin
          stall_left--;
        end
      end
      if (req_ready_o) begin
        done     = 1'b1;
        done_cyc = cyc;
      end
      @(negedge clk_i);
      wbuf_rtn_valid_i = 1'b0;
      if (wb_wait > 0) begin
        wb_wait--;
        if (wb_wait == 0) begin
          wbuf_rtn_valid_i = 1'b1;
          wbuf_rtn_data_i  = expand_word(t_wdata);
        end
      end
      biu_ready_i = (stall_left == 0);
      cyc++;
    end

    req_valid_i      = 1'b0;
    wbuf_rtn_valid_i = 1'b0;
    biu_ready_i      = 1'b1;

    if (!done) begin
      $display("timeout: request %0d (opcode %0d) saw no req_ready_o within %0d cycles",
               num, t_op, MAX_CYCLES);
      errors++;
      timed_out = 1'b1;
    end else begin
      case (bank_op_pkg::opcode_e'(t_op))
        bank_op_pkg::READ: begin
          check_value({tag, " xbar pulses"}, 256'(1), 256'(xbar_seen));
          check_value({tag, " xbar cycle"}, 256'(1), 256'(xbar_cyc));
          check_value({tag, " done cycle"}, 256'(1), 256'(done_cyc));
        end
        bank_op_pkg::READ_LINEFILL: begin
          check_value({tag, " xbar pulses"}, 256'(1), 256'(xbar_seen));
          check_value({tag, " xbar cycle"}, 256'(0), 256'(xbar_cyc));
          check_value({tag, " done cycle"}, 256'(1), 256'(done_cyc));
        end
        bank_op_pkg::WRITE: begin
          check_value({tag, " wbuf requests"}, 256'(1), 256'(wreq_seen));
          check_value({tag, " done cycle"}, 256'(t_wdly), 256'(done_cyc));
          check_value({tag, " stray xbar pulses"}, 256'(0), 256'(xbar_seen));
        end
        default: begin
          // transfer waits out every stall cycle
          check_value({tag, " biu cycles"}, 256'(int'(t_stall) + 1), 256'(biu_seen));
          check_value({tag, " done cycle"}, 256'(int'(t_stall) + 1), 256'(done_cyc));
          check_value({tag, " stray xbar pulses"}, 256'(0), 256'(xbar_seen));
        end
      endcase
      if (t_op != 3'(bank_op_pkg::WRITE)) begin
        check_value({tag, " stray wbuf requests"}, 256'(0), 256'(wreq_seen));
      end
      if (t_op != 3'(bank_op_pkg::WRITE_BACK)) begin
        check_value({tag, " stray biu cycles"}, 256'(0), 256'(biu_seen));
      end
    end
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int    fd;
    int    n;
    int    num;
    int    asrt_fails;
    string line;
    void'($urandom(32'h5933d471));
    num              = 0;
    rst_i            = 1'b1;
    req_valid_i      = 1'b0;
    req_opcode_i     = bank_op_pkg::READ;
    req_idx_i        = '0;
    req_state0_i     = bank_op_pkg::EMPTY;
    req_state1_i     = bank_op_pkg::EMPTY;
    req_wbuf_id_i    = '0;
    req_channel_i    = '0;
    req_rob_i        = '0;
    req_fill0_i      = '0;
    req_fill1_i      = '0;
    wbuf_rtn_valid_i = 1'b0;
    wbuf_rtn_data_i  = '0;
    biu_ready_i      = 1'b1;

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", TRACE_FILE);
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        if ($fgets(line, fd) == 0) begin
          break;
        end
        // skip column notes
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      t_op, t_idx, t_st0, t_st1, t_wbid, t_ch, t_rob, t_fill0, t_fill1,
                      t_wdly, t_wdata, t_stall, t_xbar, t_biu_hi, t_biu_lo, t_strb);
          if (n == 16) begin
            idle_cycles(1 + $urandom % 3);
            run_request(num);
            num++;
          end else if (n > 0) begin
            $display("trace line after request %0d is malformed", num);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    if (num == 0) begin
      $display("no request was taken from the trace file");
      errors++;
    end

    asrt_fails = i_bank_sram_controller.u_bank_sram_assertions.ready_fails
               + i_bank_sram_controller.u_bank_sram_assertions.stable_fails
               + i_bank_sram_controller.u_bank_sram_assertions.pulse_fails
               + i_bank_sram_controller.u_bank_sram_assertions.reset_fails;
    $display("requests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             num, checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bank_sram.f */
+incdir+common
common/bank_op_pkg.sv
common/bank_data_pkg.sv
src/ram_sp.sv
bank_ctrl/bank_seq_fsm.sv
bank_ctrl/bank_datapath.sv
src/bank_sram_controller.sv
tests/bank_sram_assertions.sv
tests/bank_sram_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the bank testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/bank_sram_sim

verilator --binary --timing --assert \
  -f bank_sram.f \
  --top-module bank_sram_tb \
  -o bank_sram_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation passed"
exit 0

/* tests/bank_sram_trace.txt */
# op idx st0 st1 wbid ch rob fill0 fill1 wdly wdata stall xbar biu_hi biu_lo strb
# hex fields, each data word is repeated four times to form a 128-bit half
2 04 0 0 00 0 1 a1a1a100 b2b2b201 00 00000000 00 a1a1a100 00000000 00000000 00000000
1 04 1 1 00 1 5 00000000 00000000 00 00000000 00 a1a1a100 00000000 00000000 00000000
1 05 1 1 00 2 3 00000000 00000000 00 00000000 00 b2b2b201 00000000 00000000 00000000
2 0b 1 0 00 3 7 dead0000 c3c3c311 00 00000000 00 c3c3c311 00000000 00000000 00000000
0 0a 1 1 3c 0 0 00000000 00000000 03 11223344 00 00000000 00000000 00000000 00000000
1 0a 2 1 00 1 2 00000000 00000000 00 00000000 00 11223344 00000000 00000000 00000000
1 0b 2 1 00 0 4 00000000 00000000 00 00000000 00 c3c3c311 00000000 00000000 00000000
0 05 1 1 81 0 0 00000000 00000000 01 55667788 00 00000000 00000000 00000000 00000000
1 05 1 2 00 2 6 00000000 00000000 00 00000000 00 55667788 00000000 00000000 00000000
3 04 2 2 00 0 0 00000000 00000000 00 00000000 00 00000000 55667788 a1a1a100 ffffffff
3 0a 2 1 00 0 0 00000000 00000000 00 00000000 00 00000000 00000000 11223344 0000ffff
3 0b 1 2 00 0 0 00000000 00000000 00 00000000 04 00000000 c3c3c311 00000000 ffff0000
3 04 2 2 00 0 0 00000000 00000000 00 00000000 02 00000000 55667788 a1a1a100 ffffffff
0 20 0 0 07 0 0 00000000 00000000 05 9abcdef0 00 00000000 00000000 00000000 00000000
1 20 2 0 00 3 1 00000000 00000000 00 00000000 00 9abcdef0 00000000 00000000 00000000
2 21 2 0 00 1 0 deadbeef 0f0f0f0f 00 00000000 00 0f0f0f0f 00000000 00000000 00000000
3 21 2 1 00 0 0 00000000 00000000 00 00000000 01 00000000 0f0f0f0f 9abcdef0 ffffffff
